//--- compile.f
design/ieuPkg.sv
design/aluUnit.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/ieuDatapath.sv
test/ieuDatapath_asserts.sv
test/ieuDatapath_tb.sv

//--- design/aluUnit.sv
/*
  Integer ALU for the Execute stage.
  Computes add, sub, logic, shifts and set-less-than on two words.
  sum is always srcA + srcB and serves as the memory address.
*/
`timescale 1ns/1ns

module aluUnit import ieuPkg::*; (
  input  xlenT  srcA,
  input  xlenT  srcB,
  input  aluOpT aluOp,
  output xlenT  aluResult,
  output xlenT  sum        // Address adder output
);

  logic [xlen:0] subFull;   // srcA - srcB with carry out
  xlenT          diff;
  logic          carryOut;  // High when no borrow
  logic          overflow;  // Signed overflow of the subtract
  logic          lt;        // Signed less-than
  logic          ltu;       // Unsigned less-than
  logic [4:0]    shamt;

  assign sum = srcA + srcB;

  // Subtract as srcA + ~srcB + 1
  assign subFull  = {1'b0, srcA} + {1'b0, ~srcB} + 1'b1;
  assign diff     = subFull[xlen-1:0];
  assign carryOut = subFull[xlen];

  // Compare from the subtractor
  assign overflow = (srcA[xlen-1] ^ srcB[xlen-1]) & (diff[xlen-1] ^ srcA[xlen-1]);
  assign lt       = diff[xlen-1] ^ overflow;
  assign ltu      = ~carryOut;

  assign shamt = srcB[4:0];  // Only low 5 bits shift

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (aluOp)
      aluAdd:  aluResult = sum;
      aluSub:  aluResult = diff;
      aluAnd:  aluResult = srcA & srcB;
      aluOr:   aluResult = srcA | srcB;
      aluXor:  aluResult = srcA ^ srcB;
      aluSlt:  aluResult = {{(xlen-1){1'b0}}, lt};
      aluSltu: aluResult = {{(xlen-1){1'b0}}, ltu};
      aluSll:  aluResult = srcA << shamt;
      aluSrl:  aluResult = srcA >> shamt;
      aluSra:  aluResult = xlenT'($signed(srcA) >>> shamt);  // Keep sign bit
      default: aluResult = sum;
    endcase
  end

endmodule

//--- design/decodeStage.sv
/*
  Decode stage of the integer datapath.
  Slices register fields, reads the register file with write-through
  from Writeback, and sign-extends the immediate picked by immSrcD.
*/
`timescale 1ns/1ns

module decodeStage import ieuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  xlenT    instrD,     // Instruction held in Decode
  input  immSrcT  immSrcD,    // Immediate layout from controller
  input  logic    regWriteW,  // Register write strobe from Writeback
  input  regAddrT rdW,        // Writeback destination
  input  xlenT    resultW,    // Writeback data
  output regAddrT rs1D,
  output regAddrT rs2D,
  output regAddrT rdD,
  output xlenT    r1D,        // Source 1 read data
  output xlenT    r2D,        // Source 2 read data
  output xlenT    immExtD     // Sign-extended immediate
);

  xlenT regs [nReg-1:1];  // x0 not stored

  ////////////////////////////////////////////////////////////
  // Register fields
  ////////////////////////////////////////////////////////////
  assign rs1D = instrD[19:15];
  assign rs2D = instrD[24:20];
  assign rdD  = instrD[11:7];

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////

  // Write on rising edge, x0 writes dropped
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < nReg; i++) begin
        regs[i] <= '0;
      end
    end else if (regWriteW && (rdW != '0)) begin
      regs[rdW] <= resultW;
    end
  end

  // One read port, with bypass of a same-cycle write
  function automatic xlenT readReg(input regAddrT addr);
    xlenT val;
    if (addr == '0) val = '0;                              // Hard zero
    else if (regWriteW && (rdW == addr)) val = resultW;    // Write-through
    else val = regs[addr];
    return val;
  endfunction

  always_comb begin
    r1D = readReg(rs1D);
    r2D = readReg(rs2D);
  end

  ////////////////////////////////////////////////////////////
  // Immediate extension
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (immSrcD)
      immI:    immExtD = {{20{instrD[31]}}, instrD[31:20]};
      immS:    immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
      immB:    immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                          instrD[11:8], 1'b0};  // Halfword aligned offset
      immU:    immExtD = {instrD[31:12], 12'b0};  // Upper 20 bits
      immJ:    immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                          instrD[30:21], 1'b0};
      default: immExtD = '0;  // Unused codes
    endcase
  end

endmodule

//--- design/executeStage.sv
/*
  Execute stage of the integer datapath.
  Registers Decode values, forwards operands from Memory and Writeback,
  builds branch flags and runs the ALU. ieuResultE goes on to Memory.
*/
`timescale 1ns/1ns

module executeStage import ieuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    stallE,          // Hold Execute register
  input  logic    flushE,          // Clear Execute register, wins over stall
  input  regAddrT rs1D,
  input  regAddrT rs2D,
  input  regAddrT rdD,
  input  xlenT    r1D,
  input  xlenT    r2D,
  input  xlenT    immExtD,
  input  xlenT    pcE,             // PC of the instruction in Execute
  input  xlenT    pcLinkE,         // PC + 4
  input  forwardT forwardAE,
  input  forwardT forwardBE,
  input  aluOpT   aluControlE,
  input  logic    aluSrcAE,        // Use pcE for operand A
  input  logic    aluSrcBE,        // Use immediate for operand B
  input  logic    resultSelE,      // Take alternate result over ALU
  input  logic    jumpE,           // Alternate result is pcLinkE
  input  logic    branchSignedE,   // Signed branch compare
  input  xlenT    resultW,         // Writeback result for forwarding
  input  xlenT    ifResultM,       // Memory-stage result for forwarding
  output regAddrT rs1E,
  output regAddrT rs2E,
  output regAddrT rdE,
  output xlenT    forwardedSrcAE,
  output xlenT    forwardedSrcBE,
  output xlenT    srcAE,           // Operand A after PC select
  output xlenT    ieuAdrE,         // Address adder
  output xlenT    ieuResultE,
  output flagsT   flagsE           // {equal, lessThan}
);

  xlenT r1E;
  xlenT r2E;
  xlenT immExtE;
  xlenT srcBE;
  xlenT aluResultE;
  xlenT altResultE;   // pcLinkE or immediate
  logic eqE;
  logic ltE;

  ////////////////////////////////////////////////////////////
  // Execute pipeline register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      r1E     <= '0;
      r2E     <= '0;
      immExtE <= '0;
      rs1E    <= '0;
      rs2E    <= '0;
      rdE     <= '0;
    end else if (flushE) begin  // Bubble
      r1E     <= '0;
      r2E     <= '0;
      immExtE <= '0;
      rs1E    <= '0;
      rs2E    <= '0;
      rdE     <= '0;
    end else if (!stallE) begin
      r1E     <= r1D;
      r2E     <= r2D;
      immExtE <= immExtD;
      rs1E    <= rs1D;
      rs2E    <= rs2D;
      rdE     <= rdD;
    end
  end

  ////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////

  // Same three-way pick for both operands
  function automatic xlenT fwdSelect(input forwardT sel, input xlenT regVal);
    xlenT val;
    case (sel)
      fwdWb:   val = resultW;
      fwdMem:  val = ifResultM;
      default: val = regVal;     // fwdReg
    endcase
    return val;
  endfunction

  always_comb begin
    forwardedSrcAE = fwdSelect(forwardAE, r1E);
    forwardedSrcBE = fwdSelect(forwardBE, r2E);
  end

  // Branch comparator on forwarded operands
  assign eqE = (forwardedSrcAE == forwardedSrcBE);
  assign ltE = branchSignedE ? ($signed(forwardedSrcAE) < $signed(forwardedSrcBE))
                             : (forwardedSrcAE < forwardedSrcBE);
  assign flagsE = {eqE, ltE};

  // Operand selects
  assign srcAE = aluSrcAE ? pcE : forwardedSrcAE;      // auipc, jal, branch target
  assign srcBE = aluSrcBE ? immExtE : forwardedSrcBE;

  aluUnit u_aluUnit (
    .srcA      (srcAE),
    .srcB      (srcBE),
    .aluOp     (aluControlE),
    .aluResult (aluResultE),
    .sum       (ieuAdrE)
  );

  // Execute result
  assign altResultE = jumpE ? pcLinkE : immExtE;       // Link address or lui value
  assign ieuResultE = resultSelE ? altResultE : aluResultE;

endmodule

//--- design/ieuDatapath.sv
/*
  Integer datapath top level for the five-stage RV32I core.
  Joins the Decode, Execute and Memory/Writeback stages. Selects come
  from an outside controller, stall, flush and forward from a hazard unit.
*/
`timescale 1ns/1ns

module ieuDatapath import ieuPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  // Decode
  input  xlenT      instrD,
  input  immSrcT    immSrcD,
  output regAddrT   rs1D,
  output regAddrT   rs2D,
  // Execute
  input  xlenT      pcE,
  input  xlenT      pcLinkE,
  input  logic      stallE,
  input  logic      flushE,
  input  forwardT   forwardAE,
  input  forwardT   forwardBE,
  input  aluOpT     aluControlE,
  input  logic      aluSrcAE,
  input  logic      aluSrcBE,
  input  logic      resultSelE,
  input  logic      jumpE,
  input  logic      branchSignedE,
  output regAddrT   rs1E,
  output regAddrT   rs2E,
  output regAddrT   rdE,
  output flagsT     flagsE,
  output xlenT      ieuAdrE,
  output xlenT      forwardedSrcAE,
  output xlenT      forwardedSrcBE,
  // Memory
  input  logic      stallM,
  input  logic      flushM,
  output regAddrT   rdM,
  output xlenT      srcAM,
  output xlenT      writeDataM,
  // Writeback
  input  logic      stallW,
  input  logic      flushW,
  input  logic      regWriteW,
  input  resultSrcT resultSrcW,
  input  xlenT      readDataW,
  input  xlenT      csrReadValW,
  input  xlenT      mduResultW,
  input  logic      squashScW,
  output regAddrT   rdW,
  output xlenT      resultW      // Also the retire trace value
);

  regAddrT rdD;
  xlenT    r1D, r2D, immExtD;
  xlenT    srcAE, ieuResultE;
  xlenT    ifResultM;             // Memory-stage forward path

  decodeStage u_decodeStage (
    .clk, .rstN, .instrD, .immSrcD, .regWriteW, .rdW, .resultW,
    .rs1D, .rs2D, .rdD, .r1D, .r2D, .immExtD
  );

  executeStage u_executeStage (
    .clk, .rstN, .stallE, .flushE, .rs1D, .rs2D, .rdD, .r1D, .r2D, .immExtD,
    .pcE, .pcLinkE, .forwardAE, .forwardBE, .aluControlE, .aluSrcAE, .aluSrcBE,
    .resultSelE, .jumpE, .branchSignedE, .resultW, .ifResultM,
    .rs1E, .rs2E, .rdE, .forwardedSrcAE, .forwardedSrcBE, .srcAE, .ieuAdrE,
    .ieuResultE, .flagsE
  );

  resultStage u_resultStage (
    .clk, .rstN, .stallM, .flushM, .stallW, .flushW, .srcAE, .forwardedSrcBE,
    .ieuResultE, .rdE, .resultSrcW, .readDataW, .csrReadValW, .mduResultW,
    .squashScW, .srcAM, .writeDataM, .ifResultM, .resultW, .rdM, .rdW
  );

endmodule

//--- design/ieuPkg.sv
/*
  Shared types for the RV32I integer datapath.
  Holds the data and register-index types and the select encodings
  that the stages and the outside controller agree on.
*/
package ieuPkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int xlen        = 32;  // Data word width, fixed for RV32I
  localparam int regAddrBits = 5;   // Register index width
  localparam int nReg        = 32;  // Architectural registers, x0 included

  typedef logic [xlen-1:0]        xlenT;     // Data word
  typedef logic [regAddrBits-1:0] regAddrT;  // Register index, x0 is hard zero

  // Branch flags as {equal, lessThan}
  typedef logic [1:0] flagsT;

  ////////////////////////////////////////////////////////////
  // Select encodings
  ////////////////////////////////////////////////////////////

  // ALU operation chosen by the controller
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,   // Signed set-less-than
    aluSltu,  // Unsigned set-less-than
    aluSll,
    aluSrl,
    aluSra
  } aluOpT;

  // Immediate layout in the instruction word
  typedef enum logic [2:0] {
    immI,  // Loads, ALU immediates, jalr
    immS,  // Stores
    immB,  // Branches
    immU,  // lui, auipc
    immJ   // jal
  } immSrcT;

  // Operand source in Execute
  typedef enum logic [1:0] {
    fwdReg,  // Value read in Decode
    fwdWb,   // Writeback result
    fwdMem   // Memory-stage result
  } forwardT;

  // Writeback result source
  typedef enum logic [2:0] {
    resIeu, resReadData, resCsr, resMdu, resScFail
  } resultSrcT;

endpackage

//--- design/resultStage.sv
/*
  Memory and Writeback pipeline registers of the integer datapath.
  Carries the execute result to Writeback and selects the word that
  goes back to the register file from the IEU, load, CSR, MDU or SC path.
*/
`timescale 1ns/1ns

module resultStage import ieuPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  logic      stallM,
  input  logic      flushM,
  input  logic      stallW,
  input  logic      flushW,
  input  xlenT      srcAE,           // Operand A, for CSR writes
  input  xlenT      forwardedSrcBE,  // Store data
  input  xlenT      ieuResultE,
  input  regAddrT   rdE,
  input  resultSrcT resultSrcW,
  input  xlenT      readDataW,       // Load data
  input  xlenT      csrReadValW,
  input  xlenT      mduResultW,
  input  logic      squashScW,       // Store-conditional failed
  output xlenT      srcAM,
  output xlenT      writeDataM,
  output xlenT      ifResultM,       // Forwarded back to Execute
  output xlenT      resultW,
  output regAddrT   rdM,
  output regAddrT   rdW
);

  xlenT ieuResultM;
  xlenT ifResultW;
  xlenT scResultW;

  ////////////////////////////////////////////////////////////
  // Memory pipeline register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN || flushM) begin  // flushM only seen at an edge
      {srcAM, ieuResultM, writeDataM, rdM} <= '0;
    end else if (!stallM) begin
      srcAM      <= srcAE;
      ieuResultM <= ieuResultE;
      writeDataM <= forwardedSrcBE;
      rdM        <= rdE;
    end
  end

  assign ifResultM = ieuResultM;  // No FPU result to merge

  ////////////////////////////////////////////////////////////
  // Writeback pipeline register and result select
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN || flushW) begin
      {ifResultW, rdW} <= '0;
    end else if (!stallW) begin
      ifResultW <= ifResultM;
      rdW       <= rdM;
    end
  end

  assign scResultW = {{(xlen-1){1'b0}}, squashScW};  // 1 means SC failed

  always_comb begin
    case (resultSrcW)
      resReadData: resultW = readDataW;
      resCsr:      resultW = csrReadValW;
      resMdu:      resultW = mduResultW;
      resScFail:   resultW = scResultW;
      default:     resultW = ifResultW;   // resIeu
    endcase
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the integer datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module ieuDatapath_tb -o simv > build.log 2>&1 \
  && ./obj_dir/simv 2>&1 | tee sim.log
grep -qx "TEST PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- test/ieuDatapath_asserts.sv
/*
  Concurrent checks on the integer datapath, bound to its top level.
  Covers reset state of rd, bubbles after flushE and the x0 read rule.
*/
`timescale 1ns/1ns

module ieuDatapathAsserts import ieuPkg::*; (
  input logic    clk,
  input logic    rstN,
  input logic    flushE,
  input regAddrT rdE,
  input regAddrT rdM,
  input regAddrT rdW,
  input regAddrT rs1D,
  input xlenT    r1D
);

  // Every rd is cleared while reset is held
  resetClearsRd: assert property (@(posedge clk) !rstN |-> (rdE == '0 && rdM == '0 && rdW == '0))
    else $error("rd output not zero during reset");

  // Flush leaves a bubble in Execute
  flushClearsRdE: assert property (@(posedge clk) disable iff (!rstN) flushE |=> rdE == '0)
    else $error("rdE not zero after flushE");

  x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
                                (rdW == '0 && rs1D == '0) |-> r1D == '0)
    else $error("Read of x0 returned nonzero data");

endmodule

bind ieuDatapath ieuDatapathAsserts u_ieuDatapathAsserts (
  .clk(clk), .rstN(rstN), .flushE(flushE), .rdE(rdE), .rdM(rdM), .rdW(rdW),
  .rs1D(rs1D), .r1D(r1D)
);

//--- test/ieuDatapath_tb.sv
/*
  Testbench for the integer datapath top level.
  Acts as controller and hazard unit, streams a table of instructions
  through the pipeline and checks every stage against a register model.
*/
`timescale 1ns/1ns

module ieuDatapath_tb import ieuPkg::*; ();

  typedef struct {
    xlenT      instr;
    immSrcT    imm;
    aluOpT     op;
    logic      sA, sB, rSel, jmp, bSg;  // aluSrcA/B, resultSel, jump, branchSigned
    forwardT   fa, fb;
    resultSrcT res;
    logic      wr;
  } rowT;

  localparam int maxRows = 40;

  logic clk = 1'b0, rstN, stallE, flushE, stallM, flushM, stallW, flushW;
  logic aluSrcAE, aluSrcBE, resultSelE, jumpE, branchSignedE, regWriteW, squashScW;
  xlenT instrD, pcE, pcLinkE, readDataW, csrReadValW, mduResultW;
  immSrcT    immSrcD;
  forwardT   forwardAE, forwardBE;
  aluOpT     aluControlE;
  resultSrcT resultSrcW;
  regAddrT rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
  flagsT flagsE;
  xlenT ieuAdrE, forwardedSrcAE, forwardedSrcBE, srcAM, writeDataM, resultW;

  rowT  rows [maxRows];
  int   nRows = 0;
  int   seed = 32'h7646;
  xlenT model [32];                                   // Register file mirror
  xlenT r1v[maxRows], r2v[maxRows], immv[maxRows], fBv[maxRows], srcAv[maxRows];
  xlenT ieuv[maxRows], wbv[maxRows], pcv[maxRows], rdData[maxRows], csrv[maxRows];
  xlenT mduv[maxRows];
  logic sqv[maxRows];

  ieuDatapath u_ieuDatapath (.*);

  always #10 clk = ~clk;  // 20 ns period

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic checkWord(input string name, input xlenT got, input xlenT exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic checkFlags(input string name, input flagsT got, input flagsT exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic checkReg(input string name, input regAddrT got, input regAddrT exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////
  function automatic xlenT rInstr(input regAddrT rd, input regAddrT rs1, input regAddrT rs2);
    return {7'b0, rs2, rs1, 3'b0, rd, 7'h33};  // R-type layout
  endfunction

  function automatic xlenT extendImm(input xlenT i, input immSrcT k);
    case (k)
      immS:    return {{20{i[31]}}, i[31:25], i[11:7]};
      immB:    return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
      immU:    return {i[31:12], 12'h000};
      immJ:    return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
      default: return {{20{i[31]}}, i[31:20]};  // I-type
    endcase
  endfunction

  function automatic xlenT aluModel(input aluOpT op, input xlenT a, input xlenT b);
    case (op)
      aluSub:  return a - b;
      aluAnd:  return a & b;
      aluOr:   return a | b;
      aluXor:  return a ^ b;
      aluSlt:  return {31'b0, $signed(a) < $signed(b)};
      aluSltu: return {31'b0, a < b};
      aluSll:  return a << b[4:0];
      aluSrl:  return a >> b[4:0];
      aluSra:  return xlenT'($signed(a) >>> b[4:0]);
      default: return a + b;
    endcase
  endfunction

  task automatic addRow(input xlenT instr, input immSrcT imm, input aluOpT op,
                        input logic sA, sB, rSel, jmp, bSg, input forwardT fa, fb,
                        input resultSrcT res, input logic wr);
    rows[nRows] = '{instr, imm, op, sA, sB, rSel, jmp, bSg, fa, fb, res, wr};
    pcv[nRows]    = {$random(seed)} & 32'hFFFF_FFFC;  // Word aligned PC
    rdData[nRows] = $random(seed);
    csrv[nRows]   = $random(seed);
    mduv[nRows]   = $random(seed);
    sqv[nRows]    = 1'($random(seed));
    nRows++;
  endtask

  ////////////////////////////////////////////////////////////
  // Per-stage drive and check, j is the row in that stage
  ////////////////////////////////////////////////////////////
  task automatic driveRow(input int k);
    rowT  d;
    rowT  e;
    rowT  w;
    logic eValid;
    logic wValid;
    d = (k < nRows) ? rows[k] : rows[0];
    eValid = (k >= 1) && (k - 1 < nRows);  // A row sits in Execute
    wValid = (k >= 3) && (k - 3 < nRows);  // A row sits in Writeback
    instrD  = (k < nRows) ? d.instr : '0;
    immSrcD = d.imm;
    if (eValid) begin
      e = rows[k-1];
    end else begin
      e = '{'0, immI, aluAdd, 0, 0, 0, 0, 0, fwdReg, fwdReg, resIeu, 0};  // Bubble
    end
    aluSrcAE      = e.sA;
    aluSrcBE      = e.sB;
    resultSelE    = e.rSel;
    jumpE         = e.jmp;
    branchSignedE = e.bSg;
    forwardAE     = e.fa;
    forwardBE     = e.fb;
    aluControlE   = e.op;
    pcE     = eValid ? pcv[k-1] : '0;
    pcLinkE = pcE + 32'd4;
    if (wValid) begin
      w = rows[k-3];
      regWriteW   = w.wr;
      resultSrcW  = w.res;
      readDataW   = rdData[k-3];
      csrReadValW = csrv[k-3];
      mduResultW  = mduv[k-3];
      squashScW   = sqv[k-3];
    end else begin
      regWriteW   = 1'b0;
      resultSrcW  = resIeu;
      readDataW   = '0;
      csrReadValW = '0;
      mduResultW  = '0;
      squashScW   = 1'b0;
    end
  endtask

  task automatic checkExecute(input int j);
    rowT r;
    xlenT a, b, srcB;
    r = rows[j];
    a = (r.fa == fwdWb) ? wbv[j-2] : (r.fa == fwdMem) ? ieuv[j-1] : r1v[j];
    b = (r.fb == fwdWb) ? wbv[j-2] : (r.fb == fwdMem) ? ieuv[j-1] : r2v[j];
    fBv[j]   = b;
    srcAv[j] = r.sA ? pcv[j] : a;
    srcB     = r.sB ? immv[j] : b;
    ieuv[j]  = r.rSel ? (r.jmp ? pcv[j] + 32'd4 : immv[j]) : aluModel(r.op, srcAv[j], srcB);
    checkWord("forwardedSrcAE", forwardedSrcAE, a);
    checkWord("forwardedSrcBE", forwardedSrcBE, b);
    checkFlags("flagsE", flagsE, {a == b, r.bSg ? $signed(a) < $signed(b) : a < b});
    checkWord("ieuAdrE", ieuAdrE, srcAv[j] + srcB);
    checkReg("rs1E", rs1E, r.instr[19:15]);
    checkReg("rs2E", rs2E, r.instr[24:20]);
    checkReg("rdE", rdE, r.instr[11:7]);
  endtask

  task automatic checkWriteback(input int j);
    case (rows[j].res)
      resReadData: wbv[j] = rdData[j];
      resCsr:      wbv[j] = csrv[j];
      resMdu:      wbv[j] = mduv[j];
      resScFail:   wbv[j] = {31'b0, sqv[j]};
      default:     wbv[j] = ieuv[j];
    endcase
    checkWord("resultW", resultW, wbv[j]);
    checkReg("rdW", rdW, rows[j].instr[11:7]);
    if (rows[j].wr && rows[j].instr[11:7] != 5'd0) model[rows[j].instr[11:7]] = wbv[j];
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////
  task automatic buildTable();
    for (int i = 1; i <= 8; i++)  // Load x1..x8
      addRow(rInstr(5'(i), 0, 0), immI, aluAdd, 0, 0, 0, 0, 0, fwdReg, fwdReg, resReadData, 1);
    for (int i = 0; i < 10; i++)  // Every ALU operation
      addRow(rInstr(5'(10 + i), 5'(1 + i % 8), 5'(8 - i % 8)), immI, aluOpT'(i),
             0, 0, 0, 0, i[0], fwdReg, fwdReg, resIeu, 1);
    for (int i = 0; i < 5; i++)   // Every immediate kind
      addRow($random(seed), immSrcT'(i), aluAdd, 0, 1, 0, 0, 0, fwdReg, fwdReg, resIeu, 1);
    addRow($random(seed), immJ, aluAdd, 1, 1, 1, 1, 0, fwdReg, fwdReg, resIeu, 1);  // jal
    addRow($random(seed), immU, aluAdd, 0, 1, 1, 0, 0, fwdReg, fwdReg, resIeu, 1);  // lui
    addRow($random(seed), immU, aluAdd, 1, 1, 0, 0, 0, fwdReg, fwdReg, resIeu, 1);  // auipc
    addRow(rInstr(20, 3, 4), immI, aluAdd, 0, 0, 0, 0, 1, fwdReg, fwdReg, resIeu, 1);
    addRow(rInstr(25, 20, 5), immI, aluSub, 0, 0, 0, 0, 1, fwdMem, fwdReg, resIeu, 1);
    addRow(rInstr(26, 20, 25), immI, aluXor, 0, 0, 0, 0, 0, fwdWb, fwdMem, resIeu, 1);
    addRow(rInstr(27, 6, 6), immI, aluSub, 0, 0, 0, 0, 1, fwdReg, fwdReg, resIeu, 1);  // Equal
    addRow(rInstr(21, 0, 5), immI, aluOr, 0, 0, 0, 0, 0, fwdReg, fwdReg, resIeu, 1);  // x0
    addRow(rInstr(22, 6, 7), immI, aluAdd, 0, 0, 0, 0, 0, fwdReg, fwdReg, resCsr, 1);
    addRow(rInstr(23, 6, 7), immI, aluAdd, 0, 0, 0, 0, 0, fwdReg, fwdReg, resMdu, 1);
    addRow(rInstr(24, 6, 7), immI, aluAdd, 0, 0, 0, 0, 0, fwdReg, fwdReg, resScFail, 1);
  endtask

  initial begin
    {stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    for (int i = 0; i < 32; i++) model[i] = '0;
    buildTable();
    driveRow(nRows + 3);  // All bubbles
    rstN = 1'b1;
    #1 rstN = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk) rstN = 1'b1;
    #1;
    checkReg("rdE", rdE, 0);
    checkReg("rdM", rdM, 0);
    checkReg("rdW", rdW, 0);
    checkWord("resultW", resultW, '0);
    for (int k = 0; k < nRows + 3; k++) begin
      @(negedge clk);
      driveRow(k);
      #1;
      if (k >= 3) checkWriteback(k - 3);  // Commit first, decode sees write-through
      if (k < nRows) begin
        r1v[k] = model[rows[k].instr[19:15]];
        r2v[k] = model[rows[k].instr[24:20]];
        immv[k] = extendImm(rows[k].instr, rows[k].imm);
        checkReg("rs1D", rs1D, rows[k].instr[19:15]);
        checkReg("rs2D", rs2D, rows[k].instr[24:20]);
      end
      if (k >= 1 && k - 1 < nRows) checkExecute(k - 1);
      if (k >= 2 && k - 2 < nRows) begin
        checkWord("srcAM", srcAM, srcAv[k-2]);
        checkWord("writeDataM", writeDataM, fBv[k-2]);
        checkReg("rdM", rdM, rows[k-2].instr[11:7]);
      end
    end
    // Stall holds Execute, then flush clears every stage
    @(negedge clk) instrD = rInstr(7, 1, 2);
    @(negedge clk) begin
      stallE = 1'b1;
      instrD = rInstr(9, 3, 4);
    end
    #1 checkReg("rdE", rdE, 7);
    checkWord("forwardedSrcAE", forwardedSrcAE, model[1]);
    @(negedge clk) {stallE, flushE, flushM, flushW} = 4'b0111;
    #1 checkReg("rdE", rdE, 7);
    checkWord("forwardedSrcAE", forwardedSrcAE, model[1]);
    @(negedge clk) {flushE, flushM, flushW} = '0;
    #1 checkReg("rdE", rdE, 0);
    checkReg("rdM", rdM, 0);
    checkReg("rdW", rdW, 0);
    $display("TEST PASSED");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #1;
    #((nRows * 8 + 16) * 20);
    $display("Timeout: the run did not finish within its cycle budget");
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule
